// File: cachePkg.sv
`default_nettype none

package cachePkg;

    ////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////
    localparam int TagBits       = 5;
    localparam int IndexBits     = 7;
    localparam int OffsetBits    = 3;
    localparam int NumBlocks     = 128;   // one block per index
    localparam int WordsPerBlock = 8;     // refill length

    // word address width, byte bit excluded
    localparam int WordAddrBits  = TagBits + IndexBits + OffsetBits;

    ////////////////////////////////////////
    // address views
    ////////////////////////////////////////
    // cache view of the request address
    typedef struct packed {
        logic [TagBits-1:0]    tag;
        logic [IndexBits-1:0]  index;
        logic [OffsetBits-1:0] offset;     // word within block
        logic                  byteSel;    // ignored, whole words only
    } cacheFieldsT;

    // memory view, same bits
    typedef struct packed {
        logic [WordAddrBits-1:0] wordAddr;
        logic                    byteSel;
    } flatAddrT;

    typedef union packed {
        cacheFieldsT fields;   // tag / index / offset split
        flatAddrT    flat;     // straight word address for main memory
    } cacheAddrT;

    ////////////////////////////////////////
    // metadata
    ////////////////////////////////////////
    typedef struct packed {
        logic               valid;
        logic [TagBits-1:0] tag;
    } metaEntryT;

endpackage

`default_nettype wire

// File: memPkg.sv
`default_nettype none

package memPkg;

    ////////////////////////////////////////
    // main memory timing and widths
    ////////////////////////////////////////
    localparam int MemLatency  = 4;    // cycles from read issue to data
    localparam int MemAddrBits = 15;   // word addressed
    localparam int DataBits    = 16;

    // request, one per cycle, never refused
    typedef struct packed {
        logic                   enable;
        logic                   wr;        // 1 write, 0 read
        logic [MemAddrBits-1:0] addr;
        logic [DataBits-1:0]    data;      // write data only
    } memReqT;

    // read return, writes give none
    typedef struct packed {
        logic                valid;
        logic [DataBits-1:0] data;
    } memRspT;

endpackage

`default_nettype wire

// File: cacheAddrDecode.sv
`default_nettype none

module cacheAddrDecode (
    input  cachePkg::cacheAddrT                Addr,
    input  cachePkg::metaEntryT                meta,     // entry at Addr's index
    input  logic                               Read,
    input  logic                               Write,
    output logic                               hit,
    output logic [cachePkg::IndexBits-1:0]     index,
    output logic [cachePkg::WordsPerBlock-1:0] wordSel   // one-hot
);
    import cachePkg::*;

    logic request;
    logic tagMatch;

    ////////////////////////////////////////
    // hit detect
    ////////////////////////////////////////
    assign request  = Read | Write;
    assign tagMatch = meta.tag == Addr.fields.tag;

    // idle bus never counts as a hit
    assign hit = request & meta.valid & tagMatch;

    ////////////////////////////////////////
    // array selects
    ////////////////////////////////////////
    assign index   = Addr.fields.index;                               // block row
    assign wordSel = WordsPerBlock'(1) << Addr.fields.offset;         // word column

endmodule

`default_nettype wire

// File: metaDataArray.sv
`default_nettype none

module metaDataArray (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [cachePkg::IndexBits-1:0] index,
    input  logic                           write,
    input  cachePkg::metaEntryT            dataIn,
    output cachePkg::metaEntryT            dataOut
);
    import cachePkg::*;

    logic [NumBlocks-1:0] validBits;           // cleared by reset
    logic [TagBits-1:0]   tags [NumBlocks];    // meaningless until valid

    ////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validBits <= '0;                   // whole cache empty
        end else if (write) begin
            validBits[index] <= dataIn.valid;
        end
    end

    // tag storage
    always_ff @(posedge clk) begin
        if (write) begin
            tags[index] <= dataIn.tag;
        end
    end

    ////////////////////////////////////////
    // read, combinational
    ////////////////////////////////////////
    assign dataOut.valid = validBits[index];
    assign dataOut.tag   = tags[index];

endmodule

`default_nettype wire

// File: dataArray.sv
`default_nettype none

module dataArray (
    input  logic                               clk,
    input  logic [cachePkg::IndexBits-1:0]     index,
    input  logic [cachePkg::WordsPerBlock-1:0] wordSel,   // one-hot
    input  logic                               write,
    input  logic [memPkg::DataBits-1:0]        dataIn,
    output logic [memPkg::DataBits-1:0]        dataOut
);
    import cachePkg::*;
    import memPkg::*;

    logic [DataBits-1:0]   blocks [NumBlocks][WordsPerBlock];
    logic [OffsetBits-1:0] wordIdx;                          // encoded wordSel

    // one-hot to binary for the write port
    always_comb begin
        wordIdx = '0;
        for (int w = 0; w < WordsPerBlock; w++) begin
            if (wordSel[w]) begin
                wordIdx = OffsetBits'(w);
            end
        end
    end

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (write) begin
            blocks[index][wordIdx] <= dataIn;   // hit write or refill word
        end
    end

    ////////////////////////////////////////
    // read mux, and-or over the block
    ////////////////////////////////////////
    always_comb begin
        dataOut = '0;
        for (int w = 0; w < WordsPerBlock; w++) begin
            dataOut = dataOut | (blocks[index][w] & {DataBits{wordSel[w]}});
        end
    end

endmodule

`default_nettype wire

// File: missController.sv
`default_nettype none

module missController (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               Read,
    input  logic                               Write,
    input  cachePkg::cacheAddrT                Addr,
    input  logic [memPkg::DataBits-1:0]        DataIn,
    input  logic                               hit,
    input  memPkg::memRspT                     memRsp,
    output memPkg::memReqT                     memReq,
    output logic                               Stall,
    output logic [cachePkg::IndexBits-1:0]     fillIndex,
    output logic [cachePkg::WordsPerBlock-1:0] fillWordSel,   // zero unless refilling
    output logic [memPkg::DataBits-1:0]        fillData,
    output logic                               dataWrite,
    output logic                               metaWrite,
    output cachePkg::metaEntryT                metaOut
);
    import cachePkg::*;

    typedef enum logic [2:0] {
        IDLE = 3'b000,    // no request
        CHK  = 3'b001,    // request present and hits served here
        WAIT = 3'b010,    // issuing the 8 block reads
        WRT  = 3'b011,    // draining the remaining returns
        TAG  = 3'b100     // metadata update
    } stateT;

    stateT                 state;
    stateT                 nextState;
    cacheAddrT             missAddr;     // request that missed
    cacheAddrT             issueAddr;    // word being requested
    logic [OffsetBits-1:0] issueCnt;
    logic [OffsetBits-1:0] retCnt;
    logic                  request;
    logic                  lookup;       // IDLE or CHK
    logic                  startMiss;
    logic                  writeHit;
    logic                  rspWrite;
    logic                  lastIssue;
    logic                  lastRet;

    assign request   = Read | Write;
    assign lookup    = (state == IDLE) || (state == CHK);
    assign startMiss = lookup & request & ~hit;
    assign writeHit  = lookup & Write & hit;
    assign rspWrite  = ((state == WAIT) || (state == WRT)) & memRsp.valid;
    assign lastIssue = issueCnt == OffsetBits'(WordsPerBlock - 1);
    assign lastRet   = retCnt == OffsetBits'(WordsPerBlock - 1);

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    // after the lookup cycle a miss costs 8 issues + MemLatency + last WRT + TAG
    always_comb begin
        nextState = state;
        case (state)
            IDLE, CHK: begin
                if (startMiss) begin
                    nextState = WAIT;
                end else if (request) begin
                    nextState = CHK;
                end else begin
                    nextState = IDLE;
                end
            end
            WAIT: begin
                if (lastIssue) begin
                    nextState = WRT;        // returns keep coming
                end
            end
            WRT: begin
                if (rspWrite && lastRet) begin
                    nextState = TAG;
                end
            end
            TAG:     nextState = CHK;       // retry completes as a hit
            default: nextState = CHK;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= CHK;
        end else begin
            state <= nextState;
        end
    end

    ////////////////////////////////////////
    // refill counters
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issueCnt <= '0;
            retCnt   <= '0;
        end else begin
            if (startMiss) begin
                issueCnt <= '0;
                retCnt   <= '0;
            end else begin
                if (state == WAIT) begin
                    issueCnt <= issueCnt + 1'b1;   // one read per cycle with no gaps
                end
                if (rspWrite) begin
                    retCnt <= retCnt + 1'b1;
                end
            end
        end
    end

    // fill index and tag come from the missing request
    always_ff @(posedge clk) begin
        if (startMiss) begin
            missAddr <= Addr;
        end
    end

    ////////////////////////////////////////
    // memory requests
    ////////////////////////////////////////
    always_comb begin
        issueAddr               = missAddr;
        issueAddr.fields.offset = issueCnt;      // walk the block from word 0
    end

    always_comb begin
        memReq = '0;
        if (state == WAIT) begin
            memReq.enable = 1'b1;
            memReq.wr     = 1'b0;
            memReq.addr   = issueAddr.flat.wordAddr;
        end else if (writeHit) begin
            memReq.enable = 1'b1;               // write-through on the array write edge
            memReq.wr     = 1'b1;
            memReq.addr   = Addr.flat.wordAddr;
            memReq.data   = DataIn;
        end
    end

    ////////////////////////////////////////
    // array writes and stall
    ////////////////////////////////////////
    assign fillIndex   = missAddr.fields.index;
    assign fillWordSel = rspWrite ? (WordsPerBlock'(1) << retCnt) : '0;
    assign fillData    = rspWrite ? memRsp.data : DataIn;   // refill beats processor
    assign dataWrite   = rspWrite | writeHit;
    assign metaWrite   = state == TAG;
    assign metaOut     = '{valid: 1'b1, tag: missAddr.fields.tag};

    assign Stall = lookup ? (request & ~hit) : 1'b1;

endmodule

`default_nettype wire

// File: mainMemory.sv
`default_nettype none

module mainMemory (
    input  logic           clk,
    input  logic           arstN,
    input  memPkg::memReqT memReq,
    output memPkg::memRspT memRsp
);
    import memPkg::*;

    logic [DataBits-1:0]                    mem [1 << MemAddrBits];   // 32K words
    logic                                   rdEn;                     // read accepted
    logic [MemAddrBits-1:0]                 rdAddr;
    logic [MemLatency-1:0]                  vldPipe;
    logic [MemLatency-1:0][DataBits-1:0]    dataPipe;

    // model starts empty
    initial begin
        for (int i = 0; i < (1 << MemAddrBits); i++) begin
            mem[i] = '0;
        end
    end

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (memReq.enable && memReq.wr) begin
            mem[memReq.addr] <= memReq.data;   // lands on the issuing edge
        end
        rdAddr <= memReq.addr;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdEn    <= 1'b0;
            vldPipe <= '0;
        end else begin
            rdEn    <= memReq.enable & ~memReq.wr;
            vldPipe <= {vldPipe[MemLatency-2:0], rdEn};
        end
    end

    ////////////////////////////////////////
    // return pipeline
    ////////////////////////////////////////
    // read at edge n shows up in the cycle after edge n + MemLatency
    always_ff @(posedge clk) begin
        dataPipe <= {dataPipe[MemLatency-2:0], mem[rdAddr]};
    end

    assign memRsp.valid = vldPipe[MemLatency-1];
    assign memRsp.data  = dataPipe[MemLatency-1];

endmodule

`default_nettype wire

// File: memoryCache.sv
`default_nettype none

module memoryCache (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        Read,
    input  logic                        Write,
    input  cachePkg::cacheAddrT         Addr,
    input  logic [memPkg::DataBits-1:0] DataIn,
    output logic [memPkg::DataBits-1:0] DataOut,
    output logic                        Stall
);
    import cachePkg::*;
    import memPkg::*;

    metaEntryT                metaRd;
    metaEntryT                metaWrData;
    logic                     hit;
    logic                     dataWrite;
    logic                     metaWrite;
    logic [IndexBits-1:0]     decIndex;
    logic [IndexBits-1:0]     fillIndex;
    logic [IndexBits-1:0]     dataIndex;
    logic [IndexBits-1:0]     metaIndex;
    logic [WordsPerBlock-1:0] decWordSel;
    logic [WordsPerBlock-1:0] fillWordSel;
    logic [WordsPerBlock-1:0] dataWordSel;
    logic [DataBits-1:0]      fillData;
    memReqT                   memReq;
    memRspT                   memRsp;

    ////////////////////////////////////////
    // array address mux
    ////////////////////////////////////////
    assign dataIndex   = (|fillWordSel) ? fillIndex : decIndex;   // refill word vs request
    assign dataWordSel = (|fillWordSel) ? fillWordSel : decWordSel;
    assign metaIndex   = metaWrite ? fillIndex : decIndex;

    cacheAddrDecode u_decode (
        .Addr    (Addr),
        .meta    (metaRd),
        .Read    (Read),
        .Write   (Write),
        .hit     (hit),
        .index   (decIndex),
        .wordSel (decWordSel)
    );

    metaDataArray u_meta (
        .clk     (clk),
        .arstN   (arstN),
        .index   (metaIndex),
        .write   (metaWrite),
        .dataIn  (metaWrData),
        .dataOut (metaRd)
    );

    dataArray u_data (
        .clk     (clk),
        .index   (dataIndex),
        .wordSel (dataWordSel),
        .write   (dataWrite),
        .dataIn  (fillData),
        .dataOut (DataOut)                 // valid when Stall is low
    );

    ////////////////////////////////////////
    // control and backing store
    ////////////////////////////////////////
    missController u_ctrl (
        .clk         (clk),
        .arstN       (arstN),
        .Read        (Read),
        .Write       (Write),
        .Addr        (Addr),
        .DataIn      (DataIn),
        .hit         (hit),
        .memRsp      (memRsp),
        .memReq      (memReq),
        .Stall       (Stall),
        .fillIndex   (fillIndex),
        .fillWordSel (fillWordSel),
        .fillData    (fillData),
        .dataWrite   (dataWrite),
        .metaWrite   (metaWrite),
        .metaOut     (metaWrData)
    );

    mainMemory u_mem (
        .clk    (clk),
        .arstN  (arstN),
        .memReq (memReq),
        .memRsp (memRsp)
    );

endmodule

`default_nettype wire

// File: memoryCache_sva.sv
`default_nettype none

module memoryCacheSva (
    input logic           clk,
    input logic           arstN,
    input logic           Stall,
    input logic           metaWrite,   // high only in TAG
    input memPkg::memReqT memReq,
    input memPkg::memRspT memRsp
);
    timeunit 1ns;
    timeprecision 100ps;

    import cachePkg::*;

    logic [3:0] rspCount;   // returns since the last tag write

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rspCount <= '0;
        end else if (metaWrite) begin
            rspCount <= '0;              // refill closed
        end else if (memRsp.valid) begin
            rspCount <= rspCount + 4'd1;
        end
    end

    ////////////////////////////////////////
    // properties
    ////////////////////////////////////////
    stallLowInReset: assert property (@(posedge clk) !arstN |-> !Stall)
        else $error("Stall high during reset");

    noReqInTag: assert property (@(posedge clk) disable iff (!arstN)
        metaWrite |-> !memReq.enable)
        else $error("memory request issued in TAG");

    rspPerRefill: assert property (@(posedge clk) disable iff (!arstN)
        memRsp.valid |-> rspCount < 4'(WordsPerBlock))
        else $error("more than one block of responses in a refill");

    // tag only written once the whole block is back
    tagAfterBlock: assert property (@(posedge clk) disable iff (!arstN)
        metaWrite |-> rspCount == 4'(WordsPerBlock))
        else $error("tag written before the block was complete");

endmodule

bind memoryCache memoryCacheSva u_sva (
    .clk       (clk),
    .arstN     (arstN),
    .Stall     (Stall),
    .metaWrite (metaWrite),
    .memReq    (memReq),
    .memRsp    (memRsp)
);

`default_nettype wire

// File: memoryCacheTb.sv
`default_nettype none

module memoryCacheTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cachePkg::*;
    import memPkg::*;

    // lookup cycle, then 8 issues, latency, last write and tag write
    localparam int MissCycles  = 1 + WordsPerBlock + MemLatency + 2;
    localparam int StallLimit  = 40;
    localparam int NumDirected = 18;
    localparam int NumRandom   = 64;

    typedef enum logic {OpRead, OpWrite} opT;

    typedef struct packed {
        opT                  op;
        logic [15:0]         addr;
        logic [DataBits-1:0] data;
    } dirT;

    typedef struct packed {
        opT                  op;
        cacheAddrT           addr;
        logic [DataBits-1:0] data;
        logic [DataBits-1:0] expData;   // read result from the model
        logic                expHit;
    } stimT;

    logic                clk;
    logic                arstN;
    logic                Read;
    logic                Write;
    cacheAddrT           Addr;
    logic [DataBits-1:0] DataIn;
    logic [DataBits-1:0] DataOut;
    logic                Stall;

    dirT directed [NumDirected] = '{
        '{OpRead,  16'h0000, 16'h0000},   // cold miss, memory still zero
        '{OpRead,  16'h1230, 16'h0000},
        '{OpWrite, 16'h0100, 16'hABCD},   // write miss then allocate
        '{OpRead,  16'h0100, 16'h0000},   // must hit
        '{OpRead,  16'h0002, 16'h0000},   // rest of block 0, all hits
        '{OpRead,  16'h0004, 16'h0000},
        '{OpRead,  16'h0006, 16'h0000},
        '{OpRead,  16'h0008, 16'h0000},
        '{OpRead,  16'h000A, 16'h0000},
        '{OpRead,  16'h000C, 16'h0000},
        '{OpRead,  16'h000E, 16'h0000},
        '{OpWrite, 16'h0840, 16'h1111},   // index 4, tag 1
        '{OpWrite, 16'h1040, 16'h2222},   // index 4, tag 2, evicts
        '{OpRead,  16'h0840, 16'h0000},
        '{OpRead,  16'h1040, 16'h0000},
        '{OpWrite, 16'h0840, 16'h3333},
        '{OpRead,  16'h0840, 16'h0000},
        '{OpRead,  16'h1046, 16'h0000}    // evicted again
    };

    stimT                stimTable [$];
    logic [DataBits-1:0] refMem [1 << WordAddrBits];   // backing store model
    logic                shadowValid [NumBlocks];
    logic [TagBits-1:0]  shadowTag [NumBlocks];

    memoryCache UUT (
        .clk     (clk),
        .arstN   (arstN),
        .Read    (Read),
        .Write   (Write),
        .Addr    (Addr),
        .DataIn  (DataIn),
        .DataOut (DataOut),
        .Stall   (Stall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic failRun();
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkData(input string name, input logic [DataBits-1:0] got,
                             input logic [DataBits-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%04h expected 0x%04h", name, got, exp);
            failRun();
        end
    endtask

    task automatic checkStall(input string name, input logic got, input bit exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            failRun();
        end
    endtask

    ////////////////////////////////////////
    // table build and prediction
    ////////////////////////////////////////
    task automatic buildTable();
        stimT      s;
        cacheAddrT a;
        for (int i = 0; i < NumDirected; i++) begin
            s      = '0;
            s.op   = directed[i].op;
            s.addr = directed[i].addr;
            s.data = directed[i].data;
            stimTable.push_back(s);
        end
        // small tag and index range so hits and evictions both happen
        for (int i = 0; i < NumRandom; i++) begin
            a               = '0;
            a.fields.tag    = TagBits'($urandom_range(3));
            a.fields.index  = IndexBits'($urandom_range(3));
            a.fields.offset = OffsetBits'($urandom_range(7));
            s               = '0;
            s.op            = ($urandom_range(1) == 1) ? OpWrite : OpRead;
            s.addr          = a;
            s.data          = DataBits'($urandom);
            stimTable.push_back(s);
        end
    endtask

    // direct mapped, write allocate, write through
    task automatic predictTable();
        stimT      s;
        cacheAddrT a;
        for (int i = 0; i < stimTable.size(); i++) begin
            s        = stimTable[i];
            a        = s.addr;
            s.expHit = shadowValid[a.fields.index] && (shadowTag[a.fields.index] == a.fields.tag);
            shadowValid[a.fields.index] = 1'b1;         // a miss allocates
            shadowTag[a.fields.index]   = a.fields.tag;
            if (s.op == OpWrite) begin
                refMem[a.flat.wordAddr] = s.data;
            end
            s.expData    = refMem[a.flat.wordAddr];
            stimTable[i] = s;
        end
    endtask

    ////////////////////////////////////////
    // one processor access
    ////////////////////////////////////////
    task automatic applyEntry(input stimT s);
        int stallCycles;
        bit done;
        stallCycles = s.expHit ? 0 : MissCycles;
        @(posedge clk);
        Read   <= (s.op == OpRead);
        Write  <= (s.op == OpWrite);
        Addr   <= s.addr;
        DataIn <= s.data;
        done = 1'b0;
        // sample mid cycle, inputs held while stalled
        for (int cyc = 0; cyc < StallLimit && !done; cyc++) begin
            @(negedge clk);
            checkStall($sformatf("Stall addr 0x%04h cycle %0d", s.addr, cyc), Stall,
                       cyc < stallCycles);
            done = !Stall;
        end
        if (!done) begin
            $display("Stall stayed high for %0d cycles at addr 0x%04h", StallLimit, s.addr);
            failRun();
        end
        if (s.op == OpRead) begin
            checkData($sformatf("DataOut addr 0x%04h", s.addr), DataOut, s.expData);
        end
    endtask

    initial begin
        void'($urandom(32'hc729));
        Read   = 1'b0;
        Write  = 1'b0;
        Addr   = '0;
        DataIn = '0;
        arstN  = 1'b0;
        for (int i = 0; i < (1 << WordAddrBits); i++) begin
            refMem[i] = '0;   // memory is zero after reset
        end
        for (int i = 0; i < NumBlocks; i++) begin
            shadowValid[i] = 1'b0;
            shadowTag[i]   = '0;
        end
        buildTable();
        predictTable();
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        foreach (stimTable[i]) begin
            applyEntry(stimTable[i]);
        end
        @(posedge clk);
        Read  <= 1'b0;   // last access completes here
        Write <= 1'b0;
        repeat (2) @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
cachePkg.sv
memPkg.sv
cacheAddrDecode.sv
metaDataArray.sv
dataArray.sv
missController.sv
mainMemory.sv
memoryCache.sv
memoryCache_sva.sv
memoryCacheTb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the fail message in the log
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f filelist.f \
    --top-module memoryCacheTb -o simv \
    && ./obj_dir/simv | tee sim.log \
    && ! grep -q "test failed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
